/* rtl/cnn_pkg.sv */
package cnn_pkg;

  // element and word geometry
  localparam int BYTE_W  = 8;               // one int8 weight or activation
  localparam int LANES   = 32;              // bytes per weight word
  localparam int WORD_W  = LANES * BYTE_W;  // 256-bit read word

  // 32 products of two int8 values need at most 21 bits, so 24 leaves headroom
  localparam int ACC_W   = 24;

  localparam int RADDR_W = 6;               // up to 64 weight words

  // dot-product request, act lane i sits in bits 8i+7 down to 8i
  typedef struct packed {
    logic               valid;
    logic [RADDR_W-1:0] addr;               // weight word to read
    logic [WORD_W-1:0]  act;                // 32 signed activations
  } dot_req_t;

  // dot-product response
  typedef struct packed {
    logic                    valid;
    logic signed [ACC_W-1:0] sum;           // signed sum of lane products
  } dot_rsp_t;

endpackage

/* rtl/weight_ram.sv */
module weight_ram #(
  parameter int BLOCK_BYTES = 1440
) (
  input  logic                                       clk,
  input  logic                                       wr_en,
  input  logic [$clog2(BLOCK_BYTES)-1:0]             wr_addr,  // byte address
  input  logic [cnn_pkg::BYTE_W-1:0]                 wr_data,
  input  logic [cnn_pkg::RADDR_W-1:0]                rd_addr,  // word address
  output logic [cnn_pkg::WORD_W-1:0]                 rd_data
);

  localparam int WORDS   = BLOCK_BYTES / cnn_pkg::LANES;
  localparam int WADDR_W = $clog2(BLOCK_BYTES);
  localparam int LANE_W  = $clog2(cnn_pkg::LANES);

  // each word is split into byte lanes so a single lane can be written
  logic [cnn_pkg::LANES-1:0][cnn_pkg::BYTE_W-1:0] mem [WORDS];

  logic [WADDR_W-LANE_W-1:0] wr_word;
  logic [LANE_W-1:0]         wr_lane;

  assign wr_word = wr_addr[WADDR_W-1:LANE_W];  // high bits pick the word
  assign wr_lane = wr_addr[LANE_W-1:0];        // low bits pick the lane

  // byte-wide write port
  always_ff @(posedge clk) begin
    if (wr_en) begin
      mem[wr_word][wr_lane] <= wr_data;
    end
  end

  // word-wide read port, one cycle latency
  always_ff @(posedge clk) begin
    rd_data <= mem[rd_addr];
  end

endmodule

/* rtl/weight_loader.sv */
module weight_loader #(
  parameter int BLOCK_BYTES = 1440
) (
  input  logic                           clk,
  input  logic                           rst,
  input  logic                           start,
  input  logic [cnn_pkg::BYTE_W-1:0]     s_data,
  input  logic                           s_valid,
  output logic                           s_ready,
  output logic                           done,
  output logic                           wr_en,
  output logic [$clog2(BLOCK_BYTES)-1:0] wr_addr,
  output logic [cnn_pkg::BYTE_W-1:0]     wr_data
);

  localparam int WADDR_W = $clog2(BLOCK_BYTES);

  typedef enum logic {
    ST_IDLE,
    ST_LOAD
  } state_t;

  state_t             state;
  state_t             state_nxt;
  logic [WADDR_W-1:0] byte_cnt;   // bytes accepted so far in this block
  logic               accept;
  logic               last_byte;

  assign accept    = s_valid && s_ready;
  assign last_byte = accept && (byte_cnt == WADDR_W'(BLOCK_BYTES - 1));

  always_ff @(posedge clk) begin
    if (rst) begin
      state <= ST_IDLE;
    end else begin
      state <= state_nxt;
    end
  end

  always_comb begin
    state_nxt = state;
    case (state)
      ST_IDLE: begin
        if (start) begin
          state_nxt = ST_LOAD;
        end
      end
      ST_LOAD: begin
        if (last_byte) begin
          state_nxt = ST_IDLE;           // start is ignored while loading
        end
      end
      default: state_nxt = ST_IDLE;
    endcase
  end

  // byte counter doubles as the write address
  always_ff @(posedge clk) begin
    if (rst) begin
      byte_cnt <= '0;
    end else if (last_byte) begin
      byte_cnt <= '0;
    end else if (accept) begin
      byte_cnt <= byte_cnt + 1'b1;
    end
  end

  // one-cycle pulse at the edge where s_ready drops
  always_ff @(posedge clk) begin
    if (rst) begin
      done <= 1'b0;
    end else begin
      done <= last_byte;
    end
  end

  assign s_ready = (state == ST_LOAD);   // high from the edge after start
  assign wr_en   = s_ready && s_valid;
  assign wr_addr = byte_cnt;
  assign wr_data = s_data;

endmodule

/* rtl/dot_engine.sv */
module dot_engine (
  input  logic                         clk,
  input  logic                         rst,
  input  cnn_pkg::dot_req_t            req,
  output logic [cnn_pkg::RADDR_W-1:0]  rd_addr,
  input  logic [cnn_pkg::WORD_W-1:0]   rd_data,
  output cnn_pkg::dot_rsp_t            rsp
);

  localparam int BYTE_W = cnn_pkg::BYTE_W;
  localparam int LANES  = cnn_pkg::LANES;
  localparam int ACC_W  = cnn_pkg::ACC_W;

  // stage 1, waits alongside the RAM read
  logic                      s1_valid;
  logic [cnn_pkg::WORD_W-1:0] s1_act;

  // stage 2, registered response
  logic                      s2_valid;
  logic signed [ACC_W-1:0]   s2_sum;

  logic signed [ACC_W-1:0]   dot_sum;

  assign rd_addr = req.addr;  // RAM registers the address itself

  always_ff @(posedge clk) begin
    if (rst) begin
      s1_valid <= 1'b0;
    end else begin
      s1_valid <= req.valid;
    end
  end

  always_ff @(posedge clk) begin
    s1_act <= req.act;
  end

  // 32 signed byte products summed into the accumulator width
  always_comb begin
    logic signed [BYTE_W-1:0]   w_lane;
    logic signed [BYTE_W-1:0]   a_lane;
    logic signed [2*BYTE_W-1:0] prod;
    dot_sum = '0;
    for (int i = 0; i < LANES; i++) begin
      w_lane  = rd_data[i*BYTE_W +: BYTE_W];
      a_lane  = s1_act[i*BYTE_W +: BYTE_W];
      prod    = w_lane * a_lane;
      dot_sum = dot_sum + prod;            // sign-extends to ACC_W
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      s2_valid <= 1'b0;
    end else begin
      s2_valid <= s1_valid;
    end
  end

  always_ff @(posedge clk) begin
    s2_sum <= dot_sum;
  end

  assign rsp.valid = s2_valid;
  assign rsp.sum   = s2_sum;

endmodule

/* rtl/conv_weight_top.sv */
module conv_weight_top #(
  parameter int BLOCK_BYTES = 1440   // multiple of 32, at most 64 words
) (
  input  logic                       clk,
  input  logic                       rst,
  input  logic                       start,
  input  logic [cnn_pkg::BYTE_W-1:0] s_data,
  input  logic                       s_valid,
  output logic                       s_ready,
  output logic                       done,
  input  cnn_pkg::dot_req_t          req,
  output cnn_pkg::dot_rsp_t          rsp
);

  localparam int WADDR_W = $clog2(BLOCK_BYTES);

  // loader to RAM
  logic                        wr_en;
  logic [WADDR_W-1:0]          wr_addr;
  logic [cnn_pkg::BYTE_W-1:0]  wr_data;

  // dot engine to RAM
  logic [cnn_pkg::RADDR_W-1:0] rd_addr;
  logic [cnn_pkg::WORD_W-1:0]  rd_data;

  weight_loader #(
    .BLOCK_BYTES (BLOCK_BYTES)
  ) weight_loader_inst (
    .clk     (clk),
    .rst     (rst),
    .start   (start),
    .s_data  (s_data),
    .s_valid (s_valid),
    .s_ready (s_ready),
    .done    (done),
    .wr_en   (wr_en),
    .wr_addr (wr_addr),
    .wr_data (wr_data)
  );

  weight_ram #(
    .BLOCK_BYTES (BLOCK_BYTES)
  ) weight_ram_inst (
    .clk     (clk),
    .wr_en   (wr_en),
    .wr_addr (wr_addr),
    .wr_data (wr_data),
    .rd_addr (rd_addr),
    .rd_data (rd_data)
  );

  dot_engine dot_engine_inst (
    .clk     (clk),
    .rst     (rst),
    .req     (req),
    .rd_addr (rd_addr),
    .rd_data (rd_data),
    .rsp     (rsp)
  );

endmodule

/* sim/tb_conv_weight_top.sv */
module tb_conv_weight_top;

  timeunit 1ns;
  timeprecision 1ps;

  localparam int BLOCK_BYTES = 1440;
  localparam int LANES       = cnn_pkg::LANES;
  localparam int WORD_W      = cnn_pkg::WORD_W;
  localparam int ACC_W       = cnn_pkg::ACC_W;
  localparam int TABLE_LEN   = 16;

  // mode 0 is random act, 1 all 0x7f, 2 all 0x80 and 3 all zero
  typedef struct packed {
    logic [cnn_pkg::RADDR_W-1:0] addr;
    logic [1:0]                  mode;
    logic                        b2b;    // next request follows without a gap
  } dot_entry_t;

  typedef struct packed {
    logic [31:0]       due;              // cycle count at which rsp must show
    cnn_pkg::dot_rsp_t rsp;
  } exp_entry_t;

  localparam dot_entry_t DOT_TABLE [TABLE_LEN] = '{
    '{6'd0,  2'd0, 1'b0}, '{6'd1,  2'd0, 1'b1}, '{6'd2,  2'd0, 1'b1},
    '{6'd44, 2'd0, 1'b0}, '{6'd3,  2'd1, 1'b0}, '{6'd4,  2'd2, 1'b0},
    '{6'd5,  2'd3, 1'b0}, '{6'd10, 2'd2, 1'b1}, '{6'd11, 2'd1, 1'b1},
    '{6'd12, 2'd3, 1'b1}, '{6'd20, 2'd0, 1'b0}, '{6'd20, 2'd2, 1'b1},
    '{6'd21, 2'd0, 1'b1}, '{6'd30, 2'd1, 1'b0}, '{6'd43, 2'd0, 1'b1},
    '{6'd44, 2'd2, 1'b0}
  };

  logic                       clk = 1'b0;
  logic                       rst;
  logic                       start;
  logic [cnn_pkg::BYTE_W-1:0] s_data;
  logic                       s_valid;
  logic                       s_ready;
  logic                       done;
  cnn_pkg::dot_req_t          req;
  cnn_pkg::dot_rsp_t          rsp;

  logic [7:0]  model [BLOCK_BYTES];    // expected RAM contents with byte k at index k
  exp_entry_t  exp_q [$];
  int unsigned cyc = 0;                // rising edges seen so far
  logic        mon_en = 1'b0;

  conv_weight_top conv_weight_top_inst (
    .clk     (clk),
    .rst     (rst),
    .start   (start),
    .s_data  (s_data),
    .s_valid (s_valid),
    .s_ready (s_ready),
    .done    (done),
    .req     (req),
    .rsp     (rsp)
  );

  always #2 clk = ~clk;

  always @(posedge clk) cyc <= cyc + 1;

  task automatic check_bit(string name, logic got, logic exp);
    if (got !== exp) begin
      $display("FAIL %s got %h expected %h", name, got, exp);
      $display("Simulation FAILED");
      $fatal(1, "bit mismatch");
    end
  endtask

  task automatic check_sum(string name, logic signed [ACC_W-1:0] got,
                           logic signed [ACC_W-1:0] exp);
    if (got !== exp) begin
      $display("FAIL %s got %h expected %h", name, got, exp);
      $display("Simulation FAILED");
      $fatal(1, "sum mismatch");
    end
  endtask

  task automatic check_rsp(cnn_pkg::dot_rsp_t got, cnn_pkg::dot_rsp_t exp);
    check_bit("rsp.valid", got.valid, exp.valid);
    check_sum("rsp.sum", got.sum, exp.sum);
  endtask

  // signed sum of byte products in plain integers
  function automatic logic signed [ACC_W-1:0] dot_model(int word, logic [WORD_W-1:0] act);
    int acc;
    int w;
    int a;
    acc = 0;
    for (int i = 0; i < LANES; i++) begin
      w   = int'($signed(model[word * LANES + i]));
      a   = int'($signed(act[i*8 +: 8]));
      acc = acc + w * a;
    end
    return ACC_W'(acc);
  endfunction

  function automatic logic [WORD_W-1:0] make_act(logic [1:0] mode);
    logic [WORD_W-1:0] a;
    for (int i = 0; i < LANES; i++) begin
      case (mode)
        2'd0:    a[i*8 +: 8] = 8'($urandom);
        2'd1:    a[i*8 +: 8] = 8'h7f;
        2'd2:    a[i*8 +: 8] = 8'h80;
        default: a[i*8 +: 8] = 8'h00;
      endcase
    end
    return a;
  endfunction

  // fills the model with new bytes and streams them with random gaps
  task automatic load_block();
    int   cnt;
    int   iter;
    logic v;
    cnt  = 0;
    iter = 0;
    for (int i = 0; i < BLOCK_BYTES; i++) model[i] = 8'($urandom);
    @(negedge clk);
    start = 1'b1;
    @(negedge clk);
    start = 1'b0;
    while (cnt < BLOCK_BYTES) begin
      check_bit("s_ready", s_ready, 1'b1);
      check_bit("done", done, 1'b0);
      v       = ($urandom_range(3) != 0);
      s_valid = v;
      s_data  = v ? model[cnt] : 8'($urandom);
      start   = (iter == 50);          // stray start while loading
      if (v) cnt++;
      iter++;
      @(negedge clk);
    end
    s_valid = 1'b0;
    start   = 1'b0;
    check_bit("s_ready", s_ready, 1'b0);
    check_bit("done", done, 1'b1);
    @(negedge clk);
    check_bit("s_ready", s_ready, 1'b0);
    check_bit("done", done, 1'b0);
  endtask

  task automatic issue_req(dot_entry_t e);
    logic [WORD_W-1:0] act;
    exp_entry_t        x;
    act          = make_act(e.mode);
    req.valid    = 1'b1;
    req.addr     = e.addr;
    req.act      = act;
    x.due        = cyc + 2;            // rsp shows two cycles after issue
    x.rsp.valid  = 1'b1;
    x.rsp.sum    = dot_model(int'(e.addr), act);
    exp_q.push_back(x);
    @(negedge clk);
    if (!e.b2b) begin
      req.valid = 1'b0;
      @(negedge clk);
    end
  endtask

  task automatic run_table();
    for (int i = 0; i < TABLE_LEN; i++) issue_req(DOT_TABLE[i]);
    req.valid = 1'b0;
    while (exp_q.size() != 0) @(negedge clk);
    @(negedge clk);
  endtask

  // response monitor checks order and exact latency
  always @(negedge clk) begin
    if (mon_en) begin
      if (exp_q.size() != 0 && exp_q[0].due == cyc) begin
        check_rsp(rsp, exp_q[0].rsp);
        void'(exp_q.pop_front());
      end else begin
        check_bit("rsp.valid", rsp.valid, 1'b0);
      end
    end
  end

  initial begin
    #(4 * (2 * BLOCK_BYTES * 3 + TABLE_LEN * 4 + 200));
    $display("Timeout: the run did not finish in the allowed time");
    $display("Simulation FAILED");
    $fatal(1, "watchdog expired");
  end

  initial begin
    void'($urandom(32'h393f));
    rst     = 1'b1;
    start   = 1'b0;
    s_valid = 1'b0;
    s_data  = '0;
    req     = '0;
    repeat (2) @(negedge clk);
    rst = 1'b0;
    check_bit("s_ready", s_ready, 1'b0);
    check_bit("done", done, 1'b0);
    check_bit("rsp.valid", rsp.valid, 1'b0);
    mon_en = 1'b1;
    load_block();
    run_table();
    load_block();                      // overwrite with fresh bytes
    run_table();
    $display("Simulation PASSED");
    $finish;
  end

endmodule

/* sim.f */
rtl/cnn_pkg.sv
rtl/weight_ram.sv
rtl/weight_loader.sv
rtl/dot_engine.sv
rtl/conv_weight_top.sv
sim/tb_conv_weight_top.sv

/* Makefile */
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing
TOP       ?= tb_conv_weight_top
FILELIST  ?= sim.f
LOG       ?= sim.log

.PHONY: test clean help

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST)
	./obj_dir/V$(TOP) > $(LOG) 2>&1; cat $(LOG)
	@if grep -q "Simulation PASSED" $(LOG); then \
		echo "test: pass"; \
	else \
		echo "test: fail"; \
		exit 1; \
	fi

clean:
	rm -rf obj_dir $(LOG)

help:
	@echo "targets:"
	@echo "  test   build with Verilator, run, check $(LOG)"
	@echo "  clean  remove obj_dir and $(LOG)"
	@echo "  help   show this list"
